// File: project.f
pwmCfgPkg.sv
pwmAcctPkg.sv
periodTimer.sv
pulseChannel.sv
lossMonitor.sv
motorPwmTop.sv
tbMotorPwm.sv

// File: Bender.yml
package:
  name: motor_pwm

sources:
  # packages first, then the design bottom up
  - pwmCfgPkg.sv
  - pwmAcctPkg.sv
  - periodTimer.sv
  - pulseChannel.sv
  - lossMonitor.sv
  - motorPwmTop.sv

  - target: simulation
    files:
      - tbMotorPwm.sv

// File: tbMotorPwm.sv
`timescale 1ns/1ns

module tbMotorPwm;

    localparam int numChannels      = 3;
    localparam int periodsPerWindow = 4;
    localparam int numRows          = 4;

    // one table row holds setup, per-phase request, limit and expected outcome
    typedef struct packed {
        pwmCfgPkg::countT     periodLen;
        pwmCfgPkg::posT       minPulse;
        pwmCfgPkg::posT [2:0] len;
        pwmAcctPkg::lostT     lostLimit;
        logic [7:0]           windows;
        logic                 expAlarm;
    } rowT;

    logic                   clk;
    logic                   rstN;
    logic                   active;
    pwmCfgPkg::pwmCfgT      cfg;
    pwmCfgPkg::posT         lenPos [numChannels];
    pwmAcctPkg::lostT       lostLimit;
    logic [numChannels-1:0] pwm;
    pwmAcctPkg::lostT       lost [numChannels];
    logic                   lostValid;
    logic                   lostAlarm;

    rowT rowTable [numRows];

    // reference model state per phase
    int   remModel   [numChannels];
    int   pulseModel [numChannels];
    int   wantModel  [numChannels];
    int   realModel  [numChannels];
    int   highCount  [numChannels];
    int   lostModel  [numChannels];
    logic alarmModel;
    int   windowsModel;

    motorPwmTop #(
        .numChannels     (numChannels),
        .periodsPerWindow(periodsPerWindow)
    ) i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .active   (active),
        .cfg      (cfg),
        .lenPos   (lenPos),
        .lostLimit(lostLimit),
        .pwm      (pwm),
        .lost     (lost),
        .lostValid(lostValid),
        .lostAlarm(lostAlarm)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            stopRun($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    function automatic rowT makeRow(input int periodLen, input int minPulse, input int len0,
                                    input int len1, input int len2, input int limit,
                                    input int windows, input logic expAlarm);
        rowT r;
        r.periodLen = pwmCfgPkg::countT'(periodLen);
        r.minPulse  = pwmCfgPkg::posT'(minPulse);
        r.len[0]    = pwmCfgPkg::posT'(len0);
        r.len[1]    = pwmCfgPkg::posT'(len1);
        r.len[2]    = pwmCfgPkg::posT'(len2);
        r.lostLimit = pwmAcctPkg::lostT'(limit);
        r.windows   = 8'(windows);
        r.expAlarm  = expAlarm;
        return r;
    endfunction

    // lenPos plus minPulse stays below periodLen in every row
    task automatic fillTable();
        // phase 1 loses 3 in the second window and is left holding a remainder of 6
        rowTable[0] = makeRow(40, 8, 10, 3, 20, 2, 2, 1'b1);
        // phase 0 loses 15 in the first window only so the alarm rises and then clears
        // phase 1 would fire early on a remainder kept from the row before
        rowTable[1] = makeRow(50, 16, 5, 16, 25, 10, 4, 1'b0);
        // first window loss equals the limit exactly and phase 1 stays silent
        rowTable[2] = makeRow(30, 12, 7, 0, 12, 7, 3, 1'b0);
        // minimum of one with a long pulse close to the period
        rowTable[3] = makeRow(20, 1, 1, 2, 18, 0, 2, 1'b0);
    endtask

    // outputs must rest while active is low
    task automatic checkIdle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            checkValue("pwm", 32'(pwm), 32'h0);
            checkValue("lostValid", 32'(lostValid), 32'h0);
            checkValue("lostAlarm", 32'(lostAlarm), 32'h0);
        end
    endtask

    task automatic resetModel();
        for (int ch = 0; ch < numChannels; ch++) begin
            remModel[ch]   = 0;
            pulseModel[ch] = 0;
            wantModel[ch]  = 0;
            realModel[ch]  = 0;
            highCount[ch]  = 0;
            lostModel[ch]  = 0;
        end
        alarmModel   = 1'b0;
        windowsModel = 0;
    endtask

    // one period of accumulate or fire where every fourth tick closes a window
    task automatic modelTick(input rowT r, input int tickNum);
        int   cand;
        int   diff;
        logic closing;
        logic over;
        closing = (tickNum % periodsPerWindow == 0);
        over    = 1'b0;
        for (int ch = 0; ch < numChannels; ch++) begin
            cand = remModel[ch] + int'(r.len[ch]);
            if (cand >= int'(r.minPulse)) begin
                pulseModel[ch] = cand;
                remModel[ch]   = 0;
            end else begin
                pulseModel[ch] = 0;
                remModel[ch]   = cand;
            end
            if (closing) begin
                checkValue($sformatf("pwm[%0d] high cycles", ch), highCount[ch], realModel[ch]);
                diff = wantModel[ch] - realModel[ch];
                lostModel[ch] = (diff < 0 ? -diff : diff) % 65536;
                if (lostModel[ch] > int'(r.lostLimit)) begin
                    over = 1'b1;
                end
                // the closing tick's own request opens the next window
                wantModel[ch] = int'(r.len[ch]);
                realModel[ch] = pulseModel[ch];
                highCount[ch] = 0;
            end else begin
                wantModel[ch] = wantModel[ch] + int'(r.len[ch]);
                realModel[ch] = realModel[ch] + pulseModel[ch];
            end
        end
        if (closing) begin
            alarmModel   = over;
            windowsModel = windowsModel + 1;
        end
    endtask

    task automatic runRow(input rowT r, input int rowNum);
        int   n;
        int   off;
        int   tickNum;
        int   validSeen;
        int   limit;
        int   waitCnt;
        int   periodLen;
        logic expHigh;
        periodLen = int'(r.periodLen);
        limit     = (int'(r.windows) + 1) * periodsPerWindow * periodLen + 10;
        // load the setup while idle
        @(posedge clk);
        cfg.periodLen <= r.periodLen;
        cfg.minPulse  <= r.minPulse;
        lostLimit     <= r.lostLimit;
        for (int ch = 0; ch < numChannels; ch++) begin
            lenPos[ch] <= r.len[ch];
        end
        checkIdle(3);
        resetModel();
        @(posedge clk);
        active    <= 1'b1;
        n         = 0;
        validSeen = 0;
        // every sample below sees the values held through the previous cycle
        while (validSeen < int'(r.windows)) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                stopRun($sformatf("row %0d timed out waiting for lostValid", rowNum));
            end
            off     = 0;
            tickNum = 0;
            // tick j falls in cycle j*periodLen and its pulse is seen two edges later
            if (n >= 2) begin
                off     = (n - 2) % periodLen;
                tickNum = (n - 2) / periodLen;
                if (off == 0 && tickNum >= 1) begin
                    modelTick(r, tickNum);
                end
            end
            for (int ch = 0; ch < numChannels; ch++) begin
                expHigh = (tickNum >= 1) && (off < pulseModel[ch]);
                checkValue($sformatf("pwm[%0d]", ch), 32'(pwm[ch]), 32'(expHigh));
                if (pwm[ch]) begin
                    highCount[ch]++;
                end
            end
            if (lostValid) begin
                validSeen++;
                checkValue("lostValid count", validSeen, windowsModel);
                for (int ch = 0; ch < numChannels; ch++) begin
                    checkValue($sformatf("lost[%0d]", ch), 32'(lost[ch]), lostModel[ch]);
                end
                checkValue("lostAlarm", 32'(lostAlarm), 32'(alarmModel));
            end
        end
        checkValue("lostAlarm after last window", 32'(lostAlarm), 32'(r.expAlarm));
        checkValue("modeled alarm after last window", 32'(alarmModel), 32'(r.expAlarm));
        // catch a running pulse and go idle in the middle of it
        waitCnt = 0;
        while (pwm == '0) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > 2 * periodLen + 4) begin
                stopRun($sformatf("row %0d timed out waiting for a pwm pulse", rowNum));
            end
        end
        active <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        checkValue("pwm after active dropped", 32'(pwm), 32'h0);
        checkValue("lostValid after active dropped", 32'(lostValid), 32'h0);
        checkValue("lostAlarm after active dropped", 32'(lostAlarm), 32'h0);
    endtask

    initial begin
        rstN      = 1'b0;
        active    = 1'b0;
        cfg       = '0;
        lostLimit = '0;
        for (int ch = 0; ch < numChannels; ch++) begin
            lenPos[ch] = '0;
        end
        fillTable();
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        checkIdle(4);
        for (int i = 0; i < numRows; i++) begin
            runRow(rowTable[i], i);
        end
        checkIdle(2);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: motorPwmTop.sv
`timescale 1ns/1ns

module motorPwmTop #(
    parameter int numChannels      = 3,
    parameter int periodsPerWindow = 4
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   active,
    input  pwmCfgPkg::pwmCfgT      cfg,
    input  pwmCfgPkg::posT         lenPos [numChannels],
    input  pwmAcctPkg::lostT       lostLimit,
    output logic [numChannels-1:0] pwm,
    output pwmAcctPkg::lostT       lost [numChannels],
    output logic                   lostValid,
    output logic                   lostAlarm
);

    logic                   periodTick;
    logic                   windowTick;
    pwmAcctPkg::chanReportT report [numChannels];

    // shared time base for all phases
    periodTimer #(
        .periodsPerWindow(periodsPerWindow)
    ) i_periodTimer (
        .clk       (clk),
        .rstN      (rstN),
        .active    (active),
        .cfg       (cfg),
        .periodTick(periodTick),
        .windowTick(windowTick)
    );

    for (genvar i = 0; i < numChannels; i++) begin : gChan
        pulseChannel i_pulseChannel (
            .clk       (clk),
            .rstN      (rstN),
            .active    (active),
            .cfg       (cfg),
            .periodTick(periodTick),
            .windowTick(windowTick),
            .lenPos    (lenPos[i]),
            .pwm       (pwm[i]),
            .report    (report[i])
        );
    end

    lossMonitor #(
        .numChannels(numChannels)
    ) i_lossMonitor (
        .clk       (clk),
        .rstN      (rstN),
        .active    (active),
        .windowTick(windowTick),
        .report    (report),
        .lostLimit (lostLimit),
        .lost      (lost),
        .lostValid (lostValid),
        .lostAlarm (lostAlarm)
    );

endmodule

// File: lossMonitor.sv
`timescale 1ns/1ns

module lossMonitor #(
    parameter int numChannels = 3
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   active,
    input  logic                   windowTick,
    input  pwmAcctPkg::chanReportT report [numChannels],
    input  pwmAcctPkg::lostT       lostLimit,
    output pwmAcctPkg::lostT       lost [numChannels],
    output logic                   lostValid,
    output logic                   lostAlarm
);

    localparam int signBit = $bits(pwmAcctPkg::accT) - 1;

    logic             reportFresh;
    pwmAcctPkg::accT  diff [numChannels];
    pwmAcctPkg::lostT mag [numChannels];
    logic             overLimit;

    // magnitude of want minus real per phase, any one over the limit raises the alarm
    always_comb begin
        overLimit = 1'b0;
        for (int i = 0; i < numChannels; i++) begin
            diff[i] = report[i].want - report[i].actual;
            mag[i]  = diff[i][signBit] ? -diff[i] : diff[i];
            if (mag[i] > lostLimit) begin
                overLimit = 1'b1;
            end
        end
    end

    // reports are latched by the window tick itself, so sample them one edge later
    always_ff @(posedge clk) begin
        if (!rstN || !active) begin
            reportFresh <= 1'b0;
            lostValid   <= 1'b0;
            lostAlarm   <= 1'b0;
        end else begin
            reportFresh <= windowTick;
            lostValid   <= reportFresh;
            if (reportFresh) begin
                lostAlarm <= overLimit;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < numChannels; i++) begin
            if (!rstN || !active) begin
                lost[i] <= '0;
            end else if (reportFresh) begin
                lost[i] <= mag[i];
            end
        end
    end

    // a report goes out only for a window the timer actually closed
    assert property (@(posedge clk) disable iff (!rstN)
        lostValid |-> $past(windowTick, 2))
        else $error("lostValid without a preceding windowTick");

endmodule

// File: pulseChannel.sv
`timescale 1ns/1ns

module pulseChannel (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   active,
    input  pwmCfgPkg::pwmCfgT      cfg,
    input  logic                   periodTick,
    input  logic                   windowTick,
    input  pwmCfgPkg::posT         lenPos,
    output logic                   pwm,
    output pwmAcctPkg::chanReportT report
);

    localparam pwmCfgPkg::posT posOne = pwmCfgPkg::posT'(1);

    pwmCfgPkg::posT  remainder;
    pwmCfgPkg::posT  pulseCnt;
    pwmCfgPkg::posT  candidate;
    logic            fire;
    pwmAcctPkg::accT wantSum;
    pwmAcctPkg::accT realSum;

    // on-time carried over from skipped periods plus this period's request
    assign candidate = remainder + lenPos;
    assign fire      = (candidate >= cfg.minPulse);

    // accumulate or fire on each period tick
    // a pulse loaded by the tick replaces one still running
    always_ff @(posedge clk) begin
        if (!rstN || !active) begin
            remainder <= '0;
            pulseCnt  <= '0;
        end else if (periodTick && fire) begin
            remainder <= '0;
            pulseCnt  <= candidate;
        end else begin
            if (periodTick) begin
                remainder <= candidate;
            end
            if (pulseCnt != '0) begin
                pulseCnt <= pulseCnt - posOne;
            end
        end
    end

    // output stays high for exactly the loaded number of cycles
    assign pwm = (pulseCnt != '0);

    // the window tick opens a new wanted sum with its own request
    always_ff @(posedge clk) begin
        if (!rstN || !active) begin
            wantSum <= '0;
        end else if (windowTick) begin
            wantSum <= pwmAcctPkg::accT'(lenPos);
        end else if (periodTick) begin
            wantSum <= wantSum + pwmAcctPkg::accT'(lenPos);
        end
    end

    // driven on-time counts one per high cycle
    always_ff @(posedge clk) begin
        if (!rstN || !active) begin
            realSum <= '0;
        end else if (windowTick) begin
            realSum <= '0;
        end else if (pwm) begin
            realSum <= realSum + 1'b1;
        end
    end

    // totals of the closing window without the tick's own contribution
    always_ff @(posedge clk) begin
        if (!rstN || !active) begin
            report <= '0;
        end else if (windowTick) begin
            report.want   <= wantSum;
            report.actual <= realSum;
        end
    end

    // going idle must kill a running pulse on the next edge
    assert property (@(posedge clk) disable iff (!rstN)
        !active |=> !pwm)
        else $error("pwm still high after active dropped");

    // any freshly loaded pulse is at least the minimum width
    assert property (@(posedge clk) disable iff (!rstN || !active)
        (pulseCnt != '0) && (pulseCnt != $past(pulseCnt) - posOne)
        |-> (pulseCnt >= cfg.minPulse))
        else $error("pulse loaded shorter than minPulse");

endmodule

// File: periodTimer.sv
`timescale 1ns/1ns

module periodTimer #(
    parameter int periodsPerWindow = 4
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              active,
    input  pwmCfgPkg::pwmCfgT cfg,
    output logic              periodTick,
    output logic              windowTick
);

    localparam int winW = $clog2(periodsPerWindow);
    localparam logic [winW-1:0] lastPeriod = winW'(periodsPerWindow - 1);
    localparam pwmCfgPkg::countT cntOne = pwmCfgPkg::countT'(1);

    pwmCfgPkg::countT periodCnt;
    logic [winW-1:0]  windowCnt;

    // sits at zero while idle
    // the first active edge loads a full period, then it reloads on every tick
    always_ff @(posedge clk) begin
        if (!rstN || !active) begin
            periodCnt <= '0;
        end else if (periodCnt <= cntOne) begin
            periodCnt <= cfg.periodLen;
        end else begin
            periodCnt <= periodCnt - cntOne;
        end
    end

    assign periodTick = (periodCnt == cntOne);

    // last tick of each window doubles as the window strobe
    assign windowTick = periodTick && (windowCnt == lastPeriod);

    always_ff @(posedge clk) begin
        if (!rstN || !active) begin
            windowCnt <= '0;
        end else if (periodTick) begin
            if (windowCnt == lastPeriod) begin
                windowCnt <= '0;
            end else begin
                windowCnt <= windowCnt + 1'b1;
            end
        end
    end

    // a tick is a single-cycle strobe unless the period itself is one cycle
    assert property (@(posedge clk) disable iff (!rstN)
        active && periodTick && (cfg.periodLen > cntOne) |=> !periodTick)
        else $error("periodTick high on two consecutive cycles");

endmodule

// File: pwmAcctPkg.sv
package pwmAcctPkg;

    // window sums of on-time, wrap modulo 2^16
    typedef logic [15:0] accT;

    // magnitude of wanted minus driven on-time
    typedef logic [15:0] lostT;

    // one phase's totals for the window that just closed
    // actual counts the cycles pwm was really driven high
    typedef struct packed {
        accT want;
        accT actual;
    } chanReportT;

endpackage

// File: pwmCfgPkg.sv
package pwmCfgPkg;

    // period length in clock cycles, 4095 at most
    localparam int countW = 12;

    // on-length, remainder and pulse counter width
    localparam int posW = 16;

    typedef logic [countW-1:0] countT;

    typedef logic [posW-1:0] posT;

    // static setup, only changed while the generator is idle
    typedef struct packed {
        countT periodLen;
        posT   minPulse;
    } pwmCfgT;

endpackage
